//--- Bender.yml
package:
  name: qsfp_port

sources:
  - qsfp_pkg.sv
  - apb_regport_bridge.sv
  - lane_io_regs.sv
  - lane_stream_path.sv
  - regport_resp_mux.sv
  - qsfp_port_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_qsfp_port.sv

//--- apb_regport_bridge.sv
module apb_regport_bridge
  import qsfp_pkg::*;
#(
  // Cycles a read may wait for a slave before it fails
  parameter int RD_TIMEOUT = 16
) (
  input  logic              bus_clk_i,
  input  logic              rst_n_i,

  // APB slave side
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [REG_AW-1:0] paddr_i,
  input  logic [REG_DW-1:0] pwdata_i,
  output logic [REG_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,

  // Register port master side
  output logic              reg_wr_req_o,
  output logic              reg_rd_req_o,
  output logic [REG_AW-1:0] reg_addr_o,
  output logic [REG_DW-1:0] reg_wr_data_o,
  input  logic              rd_resp_i,
  input  logic [REG_DW-1:0] rd_data_i
);

  localparam int CNT_W = $clog2(RD_TIMEOUT + 1);

  bridge_state_e    state;
  logic [CNT_W-1:0] rd_cnt;
  logic             start;
  logic             rd_expired;

  // New access phase; pready_o high means the current one is closing
  assign start      = psel_i && penable_i && !pready_o;
  assign rd_expired = (rd_cnt == CNT_W'(RD_TIMEOUT - 1));

  // ----------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state        <= ST_IDLE;
      rd_cnt       <= '0;
      reg_wr_req_o <= 1'b0;
      reg_rd_req_o <= 1'b0;
      pready_o     <= 1'b0;
      pslverr_o    <= 1'b0;
    end else begin
      // Request and completion flags are single cycle pulses
      reg_wr_req_o <= 1'b0;
      reg_rd_req_o <= 1'b0;
      pready_o     <= 1'b0;
      pslverr_o    <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            rd_cnt <= '0;
            if (pwrite_i) begin
              reg_wr_req_o <= 1'b1;
              state        <= ST_WR_ACK;
            end else begin
              reg_rd_req_o <= 1'b1;
              state        <= ST_RD_WAIT;
            end
          end
        end
        ST_WR_ACK: begin
          // Writes are posted, ack right away
          pready_o <= 1'b1;
          state    <= ST_IDLE;
        end
        ST_RD_WAIT: begin
          if (rd_resp_i) begin
            pready_o <= 1'b1;
            state    <= ST_IDLE;
          end else if (rd_expired) begin
            // Nobody owns this address
            pready_o  <= 1'b1;
            pslverr_o <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Address, write data and read data
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk_i) begin
    if (state == ST_IDLE && start) begin
      reg_addr_o    <= paddr_i;
      reg_wr_data_o <= pwdata_i;
    end
    if (state == ST_RD_WAIT) begin
      // Zero on timeout
      prdata_o <= rd_resp_i ? rd_data_i : '0;
    end
  end

endmodule

//--- lane_io_regs.sv
module lane_io_regs
  import qsfp_pkg::*;
#(
  parameter logic [7:0] PORTNUM   = 8'd0,
  parameter int         LANE      = 0,
  parameter lane_mode_e LANE_MODE = LANE_DISABLED
) (
  input  logic              bus_clk_i,
  input  logic              rst_n_i,

  // Register port
  input  logic              reg_wr_req_i,
  input  logic              reg_rd_req_i,
  input  logic [REG_AW-1:0] reg_addr_i,
  input  logic [REG_DW-1:0] reg_wr_data_i,
  output logic              rd_resp_o,
  output logic [REG_DW-1:0] rd_data_o,

  // Status
  input  logic              rx_lock_i,
  output logic              link_up_o,
  output logic [REG_DW-1:0] port_info_o
);

  logic [REG_DW-1:0]  scratch;
  logic               link_en;
  logic               hit;
  logic [WIN_LSB-1:0] offset;

  // Port, lane and mode, lowest byte reserved
  assign port_info_o = {PORTNUM, 8'(LANE), LANE_MODE, 8'h00};

  assign hit    = win_hit(reg_addr_i, LANE, WIN_IO);
  assign offset = reg_addr_i[WIN_LSB-1:0];

  // ----------------------------------------------------------
  // Writable registers and link status
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scratch   <= '0;
      link_en   <= 1'b0;
      link_up_o <= 1'b0;
    end else begin
      if (reg_wr_req_i && hit) begin
        case (offset)
          REG_SCRATCH: scratch <= reg_wr_data_i;
          REG_CTRL:    link_en <= reg_wr_data_i[0];
          default:     ;
        endcase
      end
      // A disabled lane never reports link
      link_up_o <= rx_lock_i && link_en && (LANE_MODE != LANE_DISABLED);
    end
  end

  // ----------------------------------------------------------
  // Read response
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_resp_o <= 1'b0;
      rd_data_o <= '0;
    end else begin
      rd_resp_o <= reg_rd_req_i && hit;
      if (reg_rd_req_i && hit) begin
        case (offset)
          REG_PORT_INFO: rd_data_o <= port_info_o;
          REG_SCRATCH:   rd_data_o <= scratch;
          REG_CTRL:      rd_data_o <= {{(REG_DW-1){1'b0}}, link_en};
          default:       rd_data_o <= '0;
        endcase
      end else begin
        // Keep zero so the OR merge stays clean
        rd_data_o <= '0;
      end
    end
  end

endmodule

//--- lane_stream_path.sv
module lane_stream_path
  import qsfp_pkg::*;
#(
  parameter int         LANE      = 0,
  parameter lane_mode_e LANE_MODE = LANE_DISABLED,
  parameter int         DATA_W    = 64
) (
  input  logic              bus_clk_i,
  input  logic              rst_n_i,

  // Register port
  input  logic              reg_wr_req_i,
  input  logic              reg_rd_req_i,
  input  logic [REG_AW-1:0] reg_addr_i,
  output logic              rd_resp_o,
  output logic [REG_DW-1:0] rd_data_o,

  // Transceiver receive side in, router side out
  input  logic [DATA_W-1:0] mgt_rx_tdata_i,
  input  logic              mgt_rx_tlast_i,
  input  logic              mgt_rx_tvalid_i,
  output logic              mgt_rx_tready_o,
  output logic [DATA_W-1:0] e2v_tdata_o,
  output logic              e2v_tlast_o,
  output logic              e2v_tvalid_o,
  input  logic              e2v_tready_i,

  // Router side in, transceiver transmit side out
  input  logic [DATA_W-1:0] v2e_tdata_i,
  input  logic              v2e_tlast_i,
  input  logic              v2e_tvalid_i,
  output logic              v2e_tready_o,
  output logic [DATA_W-1:0] mgt_tx_tdata_o,
  output logic              mgt_tx_tlast_o,
  output logic              mgt_tx_tvalid_o,
  input  logic              mgt_tx_tready_i,

  output logic              activity_o
);

  logic [REG_DW-1:0] rx_frames;
  logic [REG_DW-1:0] tx_frames;
  logic              rx_beat;
  logic              tx_beat;
  logic              hit;

  // ----------------------------------------------------------
  // Data path
  // ----------------------------------------------------------
  if (LANE_MODE == LANE_STREAM) begin : g_stream
    // Straight wiring, ready comes from the far side
    assign e2v_tdata_o     = mgt_rx_tdata_i;
    assign e2v_tlast_o     = mgt_rx_tlast_i;
    assign e2v_tvalid_o    = mgt_rx_tvalid_i;
    assign mgt_rx_tready_o = e2v_tready_i;
    assign mgt_tx_tdata_o  = v2e_tdata_i;
    assign mgt_tx_tlast_o  = v2e_tlast_i;
    assign mgt_tx_tvalid_o = v2e_tvalid_i;
    assign v2e_tready_o    = mgt_tx_tready_i;
  end else begin : g_disabled
    // Sink every input beat, never present one
    assign e2v_tdata_o     = '0;
    assign e2v_tlast_o     = 1'b0;
    assign e2v_tvalid_o    = 1'b0;
    assign mgt_rx_tready_o = 1'b1;
    assign mgt_tx_tdata_o  = '0;
    assign mgt_tx_tlast_o  = 1'b0;
    assign mgt_tx_tvalid_o = 1'b0;
    assign v2e_tready_o    = 1'b1;
  end

  // Accepted beats on the output sides
  assign rx_beat = e2v_tvalid_o && e2v_tready_i;
  assign tx_beat = mgt_tx_tvalid_o && mgt_tx_tready_i;

  assign hit = win_hit(reg_addr_i, LANE, WIN_STREAM);

  // ----------------------------------------------------------
  // Frame counters and activity
  // ----------------------------------------------------------
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_frames  <= '0;
      tx_frames  <= '0;
      activity_o <= 1'b0;
    end else begin
      if (reg_wr_req_i && hit) begin
        // Any write here clears both
        rx_frames <= '0;
        tx_frames <= '0;
      end else begin
        if (rx_beat && e2v_tlast_o) rx_frames <= rx_frames + 1'b1;
        if (tx_beat && mgt_tx_tlast_o) tx_frames <= tx_frames + 1'b1;
      end
      activity_o <= rx_beat || tx_beat;
    end
  end

  // Read response one cycle after the request
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_resp_o <= 1'b0;
      rd_data_o <= '0;
    end else begin
      rd_resp_o <= reg_rd_req_i && hit;
      if (reg_rd_req_i && hit) begin
        case (reg_addr_i[WIN_LSB-1:0])
          REG_RX_FRAMES: rd_data_o <= rx_frames;
          REG_TX_FRAMES: rd_data_o <= tx_frames;
          default:       rd_data_o <= '0;
        endcase
      end else begin
        rd_data_o <= '0;
      end
    end
  end

endmodule

//--- qsfp_golden.txt
// Columns, all hex: op lane addr_or_beats data expected
// op 1 write, 2 read, 3 read with slave error, 4 frames, 5 link_up_o, 6 port_info_o, 0 end
// Identity registers and port info outputs
2 0 0000 00000000 02000100
2 1 0000 00000000 02010000
2 2 0000 00000000 02020100
2 3 0000 00000000 02030000
6 0 0000 00000000 02000100
6 1 0000 00000000 02010000
6 2 0000 00000000 02020100
6 3 0000 00000000 02030000
// Scratch per lane, then lane 1 rewritten alone
1 0 0004 a5a50000 00000000
1 1 0004 5a5a0011 00000000
1 2 0004 c3c30022 00000000
1 3 0004 3c3c0033 00000000
2 0 0004 00000000 a5a50000
2 1 0004 00000000 5a5a0011
2 2 0004 00000000 c3c30022
2 3 0004 00000000 3c3c0033
1 1 0004 deadbeef 00000000
2 0 0004 00000000 a5a50000
2 1 0004 00000000 deadbeef
2 2 0004 00000000 c3c30022
2 3 0004 00000000 3c3c0033
// Unmapped read then a mapped one
3 0 2000 00000000 00000000
2 0 0008 00000000 00000000
// Frames: beats per frame, frame count, 1 when the lane passes streams
4 0 0004 00000003 00000001
4 1 0002 00000002 00000000
4 2 0003 00000005 00000001
4 3 0001 00000002 00000000
// Frame counters
2 0 1000 00000000 00000003
2 0 1004 00000000 00000003
2 1 1000 00000000 00000000
2 1 1004 00000000 00000000
2 2 1000 00000000 00000005
2 2 1004 00000000 00000005
2 3 1000 00000000 00000000
2 3 1004 00000000 00000000
// Clear lane 0 counters, lane 2 keeps its counts
1 0 1000 00000000 00000000
2 0 1000 00000000 00000000
2 0 1004 00000000 00000000
2 2 1000 00000000 00000005
// Link enable
5 0 0000 00000000 00000000
5 1 0000 00000000 00000000
5 2 0000 00000000 00000000
5 3 0000 00000000 00000000
1 0 0008 00000001 00000000
5 0 0000 00000000 00000001
1 1 0008 00000001 00000000
1 2 0008 00000001 00000000
1 3 0008 00000001 00000000
5 1 0000 00000000 00000000
5 2 0000 00000000 00000001
5 3 0000 00000000 00000000
2 0 0008 00000000 00000001
0 0 0000 00000000 00000000

//--- qsfp_pkg.sv
package qsfp_pkg;

  // ----------------------------------------------------------
  // Port geometry and register port widths
  // ----------------------------------------------------------
  localparam int NUM_LANES    = 4;
  localparam int REG_DW       = 32;
  localparam int REG_AW       = 16;
  // Lane field sits at the top two address bits, 16 KB per lane
  localparam int LANE_SEL_LSB = 14;
  // Window field is the two bits just below the lane field
  localparam int WIN_LSB      = 12;

  // Window bases inside one lane slot
  localparam logic [LANE_SEL_LSB-1:0] WIN_IO     = 14'h0000;
  localparam logic [LANE_SEL_LSB-1:0] WIN_STREAM = 14'h1000;

  // Io window offsets
  localparam logic [WIN_LSB-1:0] REG_PORT_INFO = 12'h000;
  localparam logic [WIN_LSB-1:0] REG_SCRATCH   = 12'h004;
  localparam logic [WIN_LSB-1:0] REG_CTRL      = 12'h008;

  // Stream window offsets
  localparam logic [WIN_LSB-1:0] REG_RX_FRAMES = 12'h000;
  localparam logic [WIN_LSB-1:0] REG_TX_FRAMES = 12'h004;

  // Protocol mode of one lane, reported in port info bits 15:8
  typedef enum logic [7:0] {
    LANE_DISABLED = 8'd0,
    LANE_STREAM   = 8'd1
  } lane_mode_e;

  // APB bridge FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_ACK,
    ST_RD_WAIT
  } bridge_state_e;

  // True when addr falls in the given window of the given lane
  function automatic logic win_hit(input logic [REG_AW-1:0]       addr,
                                   input int                      lane,
                                   input logic [LANE_SEL_LSB-1:0] win_base);
    logic lane_ok;
    logic win_ok;
    lane_ok = (addr[REG_AW-1:LANE_SEL_LSB] == (REG_AW-LANE_SEL_LSB)'(lane));
    win_ok  = (addr[LANE_SEL_LSB-1:WIN_LSB] == win_base[LANE_SEL_LSB-1:WIN_LSB]);
    return lane_ok && win_ok;
  endfunction

endpackage

//--- qsfp_port_top.sv
module qsfp_port_top
  import qsfp_pkg::*;
#(
  parameter logic [7:0] PORTNUM                = 8'd0,
  parameter lane_mode_e LANE_MODES [NUM_LANES] = '{default: LANE_DISABLED},
  parameter int         DATA_W                 = 64,
  parameter int         RD_TIMEOUT             = 16
) (
  input  logic                                bus_clk_i,
  input  logic                                rst_n_i,

  // APB register access
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [REG_AW-1:0]                   paddr_i,
  input  logic [REG_DW-1:0]                   pwdata_i,
  output logic [REG_DW-1:0]                   prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,

  // Per-lane stream inputs
  input  logic [NUM_LANES-1:0][DATA_W-1:0]    mgt_rx_tdata_i,
  input  logic [NUM_LANES-1:0]                mgt_rx_tlast_i,
  input  logic [NUM_LANES-1:0]                mgt_rx_tvalid_i,
  input  logic [NUM_LANES-1:0]                e2v_tready_i,
  input  logic [NUM_LANES-1:0][DATA_W-1:0]    v2e_tdata_i,
  input  logic [NUM_LANES-1:0]                v2e_tlast_i,
  input  logic [NUM_LANES-1:0]                v2e_tvalid_i,
  input  logic [NUM_LANES-1:0]                mgt_tx_tready_i,

  // Per-lane stream outputs
  output logic [NUM_LANES-1:0]                mgt_rx_tready_o,
  output logic [NUM_LANES-1:0][DATA_W-1:0]    e2v_tdata_o,
  output logic [NUM_LANES-1:0]                e2v_tlast_o,
  output logic [NUM_LANES-1:0]                e2v_tvalid_o,
  output logic [NUM_LANES-1:0]                v2e_tready_o,
  output logic [NUM_LANES-1:0][DATA_W-1:0]    mgt_tx_tdata_o,
  output logic [NUM_LANES-1:0]                mgt_tx_tlast_o,
  output logic [NUM_LANES-1:0]                mgt_tx_tvalid_o,

  // Per-lane status
  input  logic [NUM_LANES-1:0]                rx_lock_i,
  output logic [NUM_LANES-1:0]                link_up_o,
  output logic [NUM_LANES-1:0]                activity_o,
  output logic [NUM_LANES-1:0][REG_DW-1:0]    port_info_o
);

  // Io slaves in the low half, stream slaves in the high half
  localparam int NUM_SLAVES = 2 * NUM_LANES;

  logic                              reg_wr_req;
  logic                              reg_rd_req;
  logic [REG_AW-1:0]                 reg_addr;
  logic [REG_DW-1:0]                 reg_wr_data;
  logic                              rd_resp;
  logic [REG_DW-1:0]                 rd_data;
  logic [NUM_SLAVES-1:0]             sla_rd_resp;
  logic [NUM_SLAVES-1:0][REG_DW-1:0] sla_rd_data;

  // ----------------------------------------------------------
  // Register access
  // ----------------------------------------------------------
  apb_regport_bridge #(
    .RD_TIMEOUT (RD_TIMEOUT)
  ) i_bridge (
    .bus_clk_i     (bus_clk_i),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .reg_wr_req_o  (reg_wr_req),
    .reg_rd_req_o  (reg_rd_req),
    .reg_addr_o    (reg_addr),
    .reg_wr_data_o (reg_wr_data),
    .rd_resp_i     (rd_resp),
    .rd_data_i     (rd_data)
  );

  regport_resp_mux #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_resp_mux (
    .bus_clk_i     (bus_clk_i),
    .rst_n_i       (rst_n_i),
    .sla_rd_resp_i (sla_rd_resp),
    .sla_rd_data_i (sla_rd_data),
    .mst_rd_resp_o (rd_resp),
    .mst_rd_data_o (rd_data)
  );

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane

    lane_io_regs #(
      .PORTNUM   (PORTNUM),
      .LANE      (lane),
      .LANE_MODE (LANE_MODES[lane])
    ) i_io_regs (
      .bus_clk_i     (bus_clk_i),
      .rst_n_i       (rst_n_i),
      .reg_wr_req_i  (reg_wr_req),
      .reg_rd_req_i  (reg_rd_req),
      .reg_addr_i    (reg_addr),
      .reg_wr_data_i (reg_wr_data),
      .rd_resp_o     (sla_rd_resp[lane]),
      .rd_data_o     (sla_rd_data[lane]),
      .rx_lock_i     (rx_lock_i[lane]),
      .link_up_o     (link_up_o[lane]),
      .port_info_o   (port_info_o[lane])
    );

    lane_stream_path #(
      .LANE      (lane),
      .LANE_MODE (LANE_MODES[lane]),
      .DATA_W    (DATA_W)
    ) i_stream (
      .bus_clk_i       (bus_clk_i),
      .rst_n_i         (rst_n_i),
      .reg_wr_req_i    (reg_wr_req),
      .reg_rd_req_i    (reg_rd_req),
      .reg_addr_i      (reg_addr),
      .rd_resp_o       (sla_rd_resp[NUM_LANES+lane]),
      .rd_data_o       (sla_rd_data[NUM_LANES+lane]),
      .mgt_rx_tdata_i  (mgt_rx_tdata_i[lane]),
      .mgt_rx_tlast_i  (mgt_rx_tlast_i[lane]),
      .mgt_rx_tvalid_i (mgt_rx_tvalid_i[lane]),
      .mgt_rx_tready_o (mgt_rx_tready_o[lane]),
      .e2v_tdata_o     (e2v_tdata_o[lane]),
      .e2v_tlast_o     (e2v_tlast_o[lane]),
      .e2v_tvalid_o    (e2v_tvalid_o[lane]),
      .e2v_tready_i    (e2v_tready_i[lane]),
      .v2e_tdata_i     (v2e_tdata_i[lane]),
      .v2e_tlast_i     (v2e_tlast_i[lane]),
      .v2e_tvalid_i    (v2e_tvalid_i[lane]),
      .v2e_tready_o    (v2e_tready_o[lane]),
      .mgt_tx_tdata_o  (mgt_tx_tdata_o[lane]),
      .mgt_tx_tlast_o  (mgt_tx_tlast_o[lane]),
      .mgt_tx_tvalid_o (mgt_tx_tvalid_o[lane]),
      .mgt_tx_tready_i (mgt_tx_tready_i[lane]),
      .activity_o      (activity_o[lane])
    );

  end

endmodule

//--- regport_resp_mux.sv
module regport_resp_mux
  import qsfp_pkg::*;
#(
  parameter int NUM_SLAVES = 8
) (
  input  logic                                bus_clk_i,
  input  logic                                rst_n_i,
  input  logic [NUM_SLAVES-1:0]               sla_rd_resp_i,
  input  logic [NUM_SLAVES-1:0][REG_DW-1:0]   sla_rd_data_i,
  output logic                                mst_rd_resp_o,
  output logic [REG_DW-1:0]                   mst_rd_data_o
);

  logic              any_resp;
  logic [REG_DW-1:0] any_data;

  // ----------------------------------------------------------
  // OR merge, idle slaves drive zero data
  // ----------------------------------------------------------
  always_comb begin
    any_resp = 1'b0;
    any_data = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      any_resp = any_resp | sla_rd_resp_i[i];
      any_data = any_data | sla_rd_data_i[i];
    end
  end

  // One register stage toward the bridge
  always_ff @(posedge bus_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mst_rd_resp_o <= 1'b0;
      mst_rd_data_o <= '0;
    end else begin
      mst_rd_resp_o <= any_resp;
      mst_rd_data_o <= any_data;
    end
  end

endmodule

//--- tb.f
qsfp_pkg.sv
apb_regport_bridge.sv
lane_io_regs.sv
lane_stream_path.sv
regport_resp_mux.sv
qsfp_port_top.sv
tb_clock_gen.sv
tb_qsfp_port.sv

//--- tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time PERIOD       = 100ns;
  localparam int  RESET_CYCLES = 2;

  // Free running bus clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset low over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_qsfp_port.sv
module tb_qsfp_port
  import qsfp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W     = 64;
  localparam int RD_TIMEOUT = 16;
  localparam int WAIT_LIMIT = 64;
  localparam int VEC_WORDS  = 5;
  localparam int VEC_DEPTH  = 512;

  // Golden file operation codes
  localparam logic [31:0] OP_END      = 32'h0;
  localparam logic [31:0] OP_WRITE    = 32'h1;
  localparam logic [31:0] OP_READ     = 32'h2;
  localparam logic [31:0] OP_READ_ERR = 32'h3;
  localparam logic [31:0] OP_FRAMES   = 32'h4;
  localparam logic [31:0] OP_LINK     = 32'h5;
  localparam logic [31:0] OP_INFO     = 32'h6;

  logic                             bus_clk;
  logic                             rst_n;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [REG_AW-1:0]                paddr;
  logic [REG_DW-1:0]                pwdata;
  logic [REG_DW-1:0]                prdata;
  logic                             pready;
  logic                             pslverr;
  logic [NUM_LANES-1:0][DATA_W-1:0] mgt_rx_tdata;
  logic [NUM_LANES-1:0]             mgt_rx_tlast;
  logic [NUM_LANES-1:0]             mgt_rx_tvalid;
  logic [NUM_LANES-1:0]             mgt_rx_tready;
  logic [NUM_LANES-1:0][DATA_W-1:0] e2v_tdata;
  logic [NUM_LANES-1:0]             e2v_tlast;
  logic [NUM_LANES-1:0]             e2v_tvalid;
  logic [NUM_LANES-1:0]             e2v_tready;
  logic [NUM_LANES-1:0][DATA_W-1:0] v2e_tdata;
  logic [NUM_LANES-1:0]             v2e_tlast;
  logic [NUM_LANES-1:0]             v2e_tvalid;
  logic [NUM_LANES-1:0]             v2e_tready;
  logic [NUM_LANES-1:0][DATA_W-1:0] mgt_tx_tdata;
  logic [NUM_LANES-1:0]             mgt_tx_tlast;
  logic [NUM_LANES-1:0]             mgt_tx_tvalid;
  logic [NUM_LANES-1:0]             mgt_tx_tready;
  logic [NUM_LANES-1:0]             rx_lock;
  logic [NUM_LANES-1:0]             link_up;
  logic [NUM_LANES-1:0]             activity;
  logic [NUM_LANES-1:0][REG_DW-1:0] port_info;

  // Five words per vector: op, lane, address or beats, data, expected
  logic [31:0] vec_mem [VEC_DEPTH];

  int check_count;
  int err_count;
  int timeout_count;
  bit stop_run;

  tb_clock_gen i_clock_gen (
    .clk_o   (bus_clk),
    .rst_n_o (rst_n)
  );

  // Lanes 0 and 2 pass streams, 1 and 3 are disabled
  qsfp_port_top #(
    .PORTNUM    (8'h2),
    .LANE_MODES ('{LANE_STREAM, LANE_DISABLED, LANE_STREAM, LANE_DISABLED}),
    .DATA_W     (DATA_W),
    .RD_TIMEOUT (RD_TIMEOUT)
  ) i_dut (
    .bus_clk_i       (bus_clk),
    .rst_n_i         (rst_n),
    .psel_i          (psel),
    .penable_i       (penable),
    .pwrite_i        (pwrite),
    .paddr_i         (paddr),
    .pwdata_i        (pwdata),
    .prdata_o        (prdata),
    .pready_o        (pready),
    .pslverr_o       (pslverr),
    .mgt_rx_tdata_i  (mgt_rx_tdata),
    .mgt_rx_tlast_i  (mgt_rx_tlast),
    .mgt_rx_tvalid_i (mgt_rx_tvalid),
    .e2v_tready_i    (e2v_tready),
    .v2e_tdata_i     (v2e_tdata),
    .v2e_tlast_i     (v2e_tlast),
    .v2e_tvalid_i    (v2e_tvalid),
    .mgt_tx_tready_i (mgt_tx_tready),
    .mgt_rx_tready_o (mgt_rx_tready),
    .e2v_tdata_o     (e2v_tdata),
    .e2v_tlast_o     (e2v_tlast),
    .e2v_tvalid_o    (e2v_tvalid),
    .v2e_tready_o    (v2e_tready),
    .mgt_tx_tdata_o  (mgt_tx_tdata),
    .mgt_tx_tlast_o  (mgt_tx_tlast),
    .mgt_tx_tvalid_o (mgt_tx_tvalid),
    .rx_lock_i       (rx_lock),
    .link_up_o       (link_up),
    .activity_o      (activity),
    .port_info_o     (port_info)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  function automatic string lane_signal(input string name, input int lane);
    return $sformatf("%s[%0d]", name, lane);
  endfunction

  // Lane field on top, lane-relative offset below
  function automatic logic [REG_AW-1:0] lane_addr(input int lane, input logic [13:0] offset);
    return {2'(lane), offset};
  endfunction

  // Access phase is open, watch pready_o on falling edges
  task automatic wait_pready(input string what);
    int cycles;
    cycles = 0;
    @(negedge bus_clk);
    while (pready !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge bus_clk);
      cycles++;
    end
    if (pready !== 1'b1) begin
      $display("Timeout: APB %s to address 0x%04h never got pready_o", what, paddr);
      timeout_count++;
      stop_run = 1'b1;
    end
  endtask

  task automatic write_reg(input int lane, input logic [13:0] offset,
                           input logic [31:0] data);
    // Setup phase
    @(negedge bus_clk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = lane_addr(lane, offset);
    pwdata  = data;
    // Access phase
    @(negedge bus_clk);
    penable = 1'b1;
    wait_pready("write");
    if (!stop_run) begin
      compare_value("pslverr_o", 1'b0, pslverr);
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input int lane, input logic [13:0] offset,
                          input logic [31:0] expected, input bit expect_err);
    @(negedge bus_clk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = lane_addr(lane, offset);
    @(negedge bus_clk);
    penable = 1'b1;
    wait_pready("read");
    if (!stop_run) begin
      compare_value($sformatf("prdata_o at 0x%04h", paddr), expected, prdata);
      compare_value("pslverr_o", expect_err, pslverr);
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Frames both ways on one lane, random far side ready
  // ----------------------------------------------------------
  task automatic send_frames(input int lane, input int beats, input int frames,
                             input bit pass);
    int                total;
    int                rx_idx;
    int                tx_idx;
    int                idle;
    bit                rx_acc;
    bit                tx_acc;
    bit                prev_acc;
    logic [DATA_W-1:0] rx_data;
    logic [DATA_W-1:0] tx_data;
    total    = beats * frames;
    rx_idx   = 0;
    tx_idx   = 0;
    idle     = 0;
    prev_acc = 1'b0;
    rx_data  = {$urandom, $urandom};
    tx_data  = {$urandom, $urandom};
    while ((rx_idx < total || tx_idx < total) && idle < WAIT_LIMIT) begin
      @(negedge bus_clk);
      mgt_rx_tvalid[lane] = (rx_idx < total);
      mgt_rx_tdata[lane]  = rx_data;
      mgt_rx_tlast[lane]  = (rx_idx % beats == beats - 1);
      e2v_tready[lane]    = ($urandom % 4) != 0;
      v2e_tvalid[lane]    = (tx_idx < total);
      v2e_tdata[lane]     = tx_data;
      v2e_tlast[lane]     = (tx_idx % beats == beats - 1);
      mgt_tx_tready[lane] = ($urandom % 4) != 0;
      // Combinational path has settled well before the rising edge
      #10;
      if (pass) begin
        compare_value(lane_signal("e2v_tvalid_o", lane), mgt_rx_tvalid[lane], e2v_tvalid[lane]);
        compare_value(lane_signal("mgt_rx_tready_o", lane), e2v_tready[lane],
                      mgt_rx_tready[lane]);
        if (mgt_rx_tvalid[lane]) begin
          compare_value(lane_signal("e2v_tdata_o", lane), rx_data, e2v_tdata[lane]);
          compare_value(lane_signal("e2v_tlast_o", lane), mgt_rx_tlast[lane], e2v_tlast[lane]);
        end
        compare_value(lane_signal("mgt_tx_tvalid_o", lane), v2e_tvalid[lane],
                      mgt_tx_tvalid[lane]);
        compare_value(lane_signal("v2e_tready_o", lane), mgt_tx_tready[lane], v2e_tready[lane]);
        if (v2e_tvalid[lane]) begin
          compare_value(lane_signal("mgt_tx_tdata_o", lane), tx_data, mgt_tx_tdata[lane]);
          compare_value(lane_signal("mgt_tx_tlast_o", lane), v2e_tlast[lane],
                        mgt_tx_tlast[lane]);
        end
        // Activity reflects the beats moved on the last rising edge
        compare_value(lane_signal("activity_o", lane), prev_acc, activity[lane]);
      end else begin
        // Idle outputs, always ready to sink
        compare_value(lane_signal("e2v_tvalid_o", lane), 1'b0, e2v_tvalid[lane]);
        compare_value(lane_signal("mgt_tx_tvalid_o", lane), 1'b0, mgt_tx_tvalid[lane]);
        compare_value(lane_signal("mgt_rx_tready_o", lane), 1'b1, mgt_rx_tready[lane]);
        compare_value(lane_signal("v2e_tready_o", lane), 1'b1, v2e_tready[lane]);
      end
      // Beat moves on the next rising edge when valid meets ready
      rx_acc = mgt_rx_tvalid[lane] && mgt_rx_tready[lane];
      tx_acc = v2e_tvalid[lane] && v2e_tready[lane];
      if (rx_acc) begin
        rx_idx++;
        rx_data = {$urandom, $urandom};
      end
      if (tx_acc) begin
        tx_idx++;
        tx_data = {$urandom, $urandom};
      end
      idle     = (rx_acc || tx_acc) ? 0 : idle + 1;
      prev_acc = rx_acc || tx_acc;
    end
    @(negedge bus_clk);
    mgt_rx_tvalid[lane] = 1'b0;
    mgt_rx_tlast[lane]  = 1'b0;
    v2e_tvalid[lane]    = 1'b0;
    v2e_tlast[lane]     = 1'b0;
    e2v_tready[lane]    = 1'b1;
    mgt_tx_tready[lane] = 1'b1;
    if (idle >= WAIT_LIMIT) begin
      $display("Timeout: lane %0d stream beats were not accepted", lane);
      timeout_count++;
      stop_run = 1'b1;
    end
  endtask

  // Link status is registered, look one falling edge later
  task automatic check_link(input int lane, input logic expected);
    @(negedge bus_clk);
    compare_value(lane_signal("link_up_o", lane), expected, link_up[lane]);
  endtask

  // ----------------------------------------------------------
  // Vector runner
  // ----------------------------------------------------------
  initial begin
    int          cycles;
    int          idx;
    int          base;
    int          lane;
    bit          done;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] expected;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    mgt_rx_tdata  = '0;
    mgt_rx_tlast  = '0;
    mgt_rx_tvalid = '0;
    e2v_tready    = '1;
    v2e_tdata     = '0;
    v2e_tlast     = '0;
    v2e_tvalid    = '0;
    mgt_tx_tready = '1;
    rx_lock       = '1;
    check_count   = 0;
    err_count     = 0;
    timeout_count = 0;
    stop_run      = 1'b0;
    void'($urandom(32'h2522));
    $readmemh("qsfp_golden.txt", vec_mem);

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge bus_clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeout_count++;
      stop_run = 1'b1;
    end else begin
      // Quiet outputs out of reset
      compare_value("pready_o", 1'b0, pready);
      compare_value("pslverr_o", 1'b0, pslverr);
      compare_value("link_up_o", '0, link_up);
      compare_value("activity_o", '0, activity);
    end

    idx  = 0;
    done = 1'b0;
    while (!done && !stop_run) begin
      base = idx * VEC_WORDS;
      if (base + VEC_WORDS > VEC_DEPTH) begin
        $display("Golden file ends without an end marker");
        err_count++;
        done = 1'b1;
      end else begin
        op       = vec_mem[base];
        lane     = int'(vec_mem[base+1]);
        arg      = vec_mem[base+2];
        data     = vec_mem[base+3];
        expected = vec_mem[base+4];
        case (op)
          OP_END:      done = 1'b1;
          OP_WRITE:    write_reg(lane, arg[13:0], data);
          OP_READ:     read_reg(lane, arg[13:0], expected, 1'b0);
          OP_READ_ERR: read_reg(lane, arg[13:0], expected, 1'b1);
          OP_FRAMES:   send_frames(lane, int'(arg), int'(data), expected[0]);
          OP_LINK:     check_link(lane, expected[0]);
          OP_INFO: begin
            compare_value(lane_signal("port_info_o", lane), expected, port_info[lane]);
          end
          default: begin
            $display("Golden vector %0d has an unknown operation 0x%0h", idx, op);
            err_count++;
            done = 1'b1;
          end
        endcase
        idx++;
      end
    end

    $display("Vectors %0d, checks %0d, errors %0d, timeouts %0d",
             idx, check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
